//--- tb.f
+incdir+dv
logic/spart_driver_pkg.sv
logic/frame_if.sv
logic/dump_if.sv
logic/frame_decode.sv
logic/command_fsm.sv
logic/result_dump.sv
logic/spart_driver.sv
dv/tb_spart_driver.sv

//--- run.sh
#!/bin/sh
# build the spart driver testbench with verilator, run it, and look for the pass line
rm -rf obj_dir sim.log
verilator --binary --timing --assert -sv -f tb.f --top-module tb_spart_driver -Mdir obj_dir \
   && ./obj_dir/Vtb_spart_driver | tee sim.log \
   && grep -q '^Result: PASSED$' sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

//--- dv/tb_cases.svh
// test table for the spart driver testbench, included inside the testbench top module
`ifndef TB_CASES_SVH
`define TB_CASES_SVH

// baud setting held through reset and the divisor it must produce
localparam br_cfg_t  RESET_BR  = 2'd1;
localparam divisor_t RESET_DIV = 16'h028B;

localparam int NUM_CASES = 10;

// columns, one row per test
//   name, br_cfg to apply, divisor expected when br_cfg changes,
//   characters to send (eight digits and a command, or none),
//   cpu run length in cycles, cycles from flush to mem_sys_fin, dump bytes expected
string case_name [NUM_CASES] = '{
   "baud_to_0", "start_addr", "stop_addr", "run_four_words", "baud_to_3",
   "start_above_stop", "inverted_run", "baud_to_2", "stop_single", "run_one_word"
};
br_cfg_t case_br [NUM_CASES] = '{
   2'd0, 2'd0, 2'd0, 2'd0, 2'd3, 2'd3, 2'd3, 2'd2, 2'd2, 2'd2
};
divisor_t case_div [NUM_CASES] = '{
   16'h0082, 16'h0082, 16'h0082, 16'h0082, 16'h00A3,
   16'h00A3, 16'h00A3, 16'h0146, 16'h0146, 16'h0146
};
// start 0x0100, stop 0x0103, then start 0x0300 above the stop,
// then start and stop both 0x0302; ':' is digit value 0x0a
string case_chars [NUM_CASES] = '{
   "", "00000010a", "00000013e", "00000012s", "",
   "00000030a", "00000045s", "98765432a", "00000032e", "0000001:s"
};
int case_run [NUM_CASES] = '{0, 0, 0, 6, 0, 0, 3, 0, 0, 8};
int case_fin [NUM_CASES] = '{0, 0, 0, 5, 0, 0, 2, 0, 0, 11};
int case_bytes [NUM_CASES] = '{0, 0, 0, 32, 0, 0, 0, 0, 0, 8};

`endif

//--- dv/tb_spart_driver.sv
`timescale 1ns/1ps
// self-checking testbench of the spart driver with spart, memory and cpu models, run by run.sh
module tb_spart_driver
   import spart_driver_pkg::*;
();

   `include "tb_cases.svh"

   localparam maddr_t SLOT_ADDR_EXP = 14'h3fff;
   // pc the cpu model parks at inside the loader loop
   localparam pc_t    LOOP_PC       = 16'h0002;

   logic    clk;
   logic    rst_n;
   br_cfg_t br_cfg_i;
   logic    rda_i;
   logic    tbr_i;
   byte_t   rx_data_i;
   word_t   mem_rdata_i;
   pc_t     cpu_pc_i;
   logic    mem_sys_fin_i;
   ioaddr_t ioaddr_o;
   logic    iorw_o;
   byte_t   tx_data_o;
   logic    mem_en_o;
   logic    mem_we_o;
   maddr_t  mem_addr_o;
   word_t   mem_wdata_o;
   pc_t     ext_pc_o;
   logic    ext_pc_en_o;
   logic    flush_o;

   // values the sequence wants on the next falling edge
   logic    rst_d;
   br_cfg_t br_d;
   logic    rda_d;
   byte_t   rx_d;
   logic    fin_d;

   // model state
   word_t       mem_model [16384];
   logic        rd_pend;
   maddr_t      rd_addr;
   logic [31:0] lfsr;
   logic        jump_pend;
   pc_t         jump_target;
   int          run_left;
   int          run_len_cur;
   byte_t       div_low;
   logic        wait_fin;

   // what the models saw
   byte_t    tx_q [$];
   divisor_t div_q [$];
   logic     taken;
   int       jump_cnt;
   maddr_t   jump_addr;
   word_t    jump_data;
   int       flush_cnt;
   int       early_tx;
   maddr_t   exp_start;
   maddr_t   exp_stop;

   string cur_name;
   int    case_err;
   int    pass_cnt;
   int    fail_cnt;

   spart_driver dut0 (.*);

   always #20 clk = ~clk;

   // fibonacci lfsr with taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // pattern over every address bit
   function automatic word_t fill_word(input maddr_t a);
      logic [31:0] h;
      h = {18'h0, a} * 32'h9e3779b1;
      return {2'b01, a, 2'b10, ~a, h};
   endfunction

   // digits as values with the earliest digit in the top byte
   function automatic word_t frame_word(input string s);
      word_t w;
      w = '0;
      for (int i = 0; i < 8; i++)
      begin
         w[63 - 8*i -: 8] = s[i] - 8'h30;
      end
      return w;
   endfunction

   task automatic check_value(input string what, input logic [63:0] exp_v,
                              input logic [63:0] act_v);
      if (exp_v !== act_v)
      begin
         $display("Error %s, %s: expected %0h, actual %0h", cur_name, what, exp_v, act_v);
         case_err++;
      end
   endtask

   task automatic report_timeout(input string what);
      $display("test %s timed out waiting for %s", cur_name, what);
      case_err++;
   endtask

   //////////////////////////////////////////////////
   // one clock cycle of all models
   //////////////////////////////////////////////////
   task automatic sample_outputs();
      rd_pend = 1'b0;
      if (mem_en_o && mem_we_o)
      begin
         mem_model[mem_addr_o] = mem_wdata_o;
         if (ext_pc_en_o)
         begin
            jump_cnt++;
            jump_addr = mem_addr_o;
            jump_data = mem_wdata_o;
         end
      end
      else if (mem_en_o)
      begin
         rd_pend = 1'b1;
         rd_addr = mem_addr_o;
      end
      // cpu takes the new pc on the next cycle
      if (ext_pc_en_o)
      begin
         jump_pend   = 1'b1;
         jump_target = ext_pc_o;
         run_left    = run_len_cur;
      end
      if (!iorw_o && ioaddr_o == IOADDR_DATA)
      begin
         tx_q.push_back(tx_data_o);
         if (wait_fin)
         begin
            early_tx++;
         end
      end
      if (ioaddr_o == IOADDR_DIV_LOW)
      begin
         div_low = tx_data_o;
      end
      if (ioaddr_o == IOADDR_DIV_HIGH)
      begin
         div_q.push_back({tx_data_o, div_low});
      end
      if (rda_i && iorw_o && ioaddr_o == IOADDR_DATA)
      begin
         taken = 1'b1;
      end
      if (flush_o)
      begin
         flush_cnt++;
         wait_fin = 1'b1;
      end
   endtask

   // drive on the falling edge, sample halfway to the rising edge
   task automatic step();
      @(negedge clk);
      rst_n         = rst_d;
      br_cfg_i      = br_d;
      rda_i         = rda_d;
      rx_data_i     = rx_d;
      mem_sys_fin_i = fin_d;
      if (fin_d)
      begin
         wait_fin = 1'b0;
      end
      lfsr  = lfsr_step(lfsr);
      tbr_i = lfsr[0];
      if (rd_pend)
      begin
         mem_rdata_i = mem_model[rd_addr];
      end
      if (jump_pend)
      begin
         cpu_pc_i  = jump_target;
         jump_pend = 1'b0;
      end
      else if (run_left > 0)
      begin
         run_left--;
         cpu_pc_i = (run_left == 0) ? LOOP_PC : cpu_pc_i + 16'd1;
      end
      #10;
      if (rst_n)
      begin
         sample_outputs();
      end
   endtask

   //////////////////////////////////////////////////
   // sequence tasks
   //////////////////////////////////////////////////
   task automatic wait_divisor(input divisor_t exp_div);
      int n;
      n = 0;
      while (div_q.size() == 0 && n < 50)
      begin
         step();
         n++;
      end
      if (div_q.size() == 0)
      begin
         report_timeout("divisor write");
      end
      else
      begin
         check_value("divisor", 64'(exp_div), 64'(div_q.pop_front()));
      end
   endtask

   task automatic send_char(input byte_t c);
      int n;
      check_value("stray bytes", 64'd0, 64'(tx_q.size()));
      tx_q.delete();
      taken = 1'b0;
      rda_d = 1'b1;
      rx_d  = c;
      n     = 0;
      while (!taken && n < 200)
      begin
         step();
         n++;
      end
      rda_d = 1'b0;
      if (!taken)
      begin
         report_timeout("character take");
      end
      n = 0;
      while (tx_q.size() == 0 && n < 200)
      begin
         step();
         n++;
      end
      if (tx_q.size() == 0)
      begin
         report_timeout("echo");
      end
      else
      begin
         check_value("echo", 64'(c), 64'(tx_q.pop_front()));
      end
   endtask

   task automatic run_program(input int k);
      int    n;
      int    count;
      word_t w;
      word_t fw;
      w = frame_word(case_chars[k]);
      n = 0;
      while (jump_cnt == 0 && n < 50)
      begin
         step();
         n++;
      end
      if (jump_cnt == 0)
      begin
         report_timeout("slot write and jump");
      end
      check_value("slot address", 64'(SLOT_ADDR_EXP), 64'(jump_addr));
      check_value("slot data", w, jump_data);
      check_value("ext pc", 64'(w[15:0]), 64'(jump_target));
      n = 0;
      while (flush_cnt == 0 && n < case_run[k] + 50)
      begin
         step();
         n++;
      end
      if (flush_cnt == 0)
      begin
         report_timeout("flush");
      end
      // memory system still busy
      repeat (case_fin[k]) step();
      fin_d = 1'b1;
      step();
      fin_d = 1'b0;
      count = case_bytes[k];
      n = 0;
      while (tx_q.size() < count && n < 4000)
      begin
         step();
         n++;
      end
      if (tx_q.size() < count)
      begin
         report_timeout("dump bytes");
      end
      // most significant byte of each word first
      for (int a = int'(exp_start); a <= int'(exp_stop); a++)
      begin
         fw = fill_word(maddr_t'(a));
         for (int b = 7; b >= 0; b--)
         begin
            if (tx_q.size() > 0)
            begin
               check_value("dump byte", 64'(fw[8*b +: 8]), 64'(tx_q.pop_front()));
            end
         end
      end
      // nothing more may be sent during a quiet period
      repeat (20) step();
      check_value("extra dump bytes", 64'd0, 64'(tx_q.size()));
      check_value("flush pulses", 64'd1, 64'(flush_cnt));
      check_value("bytes before fin", 64'd0, 64'(early_tx));
      check_value("cleared slot", 64'd0, mem_model[SLOT_ADDR_EXP]);
   endtask

   task automatic close_case();
      if (case_err == 0)
      begin
         pass_cnt++;
         $display("test %s: ok", cur_name);
      end
      else
      begin
         fail_cnt++;
         $display("test %s: %0d errors", cur_name, case_err);
      end
   endtask

   task automatic run_case(input int k);
      string s;
      word_t w;
      s           = case_chars[k];
      cur_name    = case_name[k];
      case_err    = 0;
      jump_cnt    = 0;
      flush_cnt   = 0;
      early_tx    = 0;
      run_len_cur = case_run[k];
      if (case_br[k] != br_d)
      begin
         div_q.delete();
         br_d = case_br[k];
         wait_divisor(case_div[k]);
      end
      for (int i = 0; i < s.len(); i++)
      begin
         send_char(s[i]);
      end
      // region bounds are the low 14 bits of the frame word
      if (s.len() == 9)
      begin
         w = frame_word(s);
         if (s[8] == "a")
         begin
            exp_start = w[13:0];
            // the command runs in the idle cycle after its echo while rda stays low
            step();
         end
         else if (s[8] == "e")
         begin
            exp_stop = w[13:0];
            step();
         end
         else if (s[8] == "s")
         begin
            run_program(k);
         end
      end
      close_case();
   endtask

   //////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////
   initial
   begin
      clk           = 1'b0;
      rst_n         = 1'b0;
      br_cfg_i      = RESET_BR;
      rda_i         = 1'b0;
      tbr_i         = 1'b0;
      rx_data_i     = '0;
      mem_rdata_i   = '0;
      cpu_pc_i      = LOOP_PC;
      mem_sys_fin_i = 1'b0;
      rst_d         = 1'b0;
      br_d          = RESET_BR;
      rda_d         = 1'b0;
      rx_d          = '0;
      fin_d         = 1'b0;
      lfsr          = 32'h06c95121;
      rd_pend       = 1'b0;
      rd_addr       = '0;
      jump_pend     = 1'b0;
      jump_target   = '0;
      run_left      = 0;
      run_len_cur   = 0;
      div_low       = '0;
      wait_fin      = 1'b0;
      exp_start     = '0;
      exp_stop      = '0;
      pass_cnt      = 0;
      fail_cnt      = 0;
      for (int a = 0; a < 16384; a++)
      begin
         mem_model[a] = fill_word(maddr_t'(a));
      end
      repeat (16) step();
      rst_d    = 1'b1;
      cur_name = "reset_divisor";
      case_err = 0;
      wait_divisor(RESET_DIV);
      close_case();
      for (int k = 0; k < NUM_CASES; k++)
      begin
         run_case(k);
      end
      $display("tests %0d, passed %0d, failed %0d", pass_cnt + fail_cnt, pass_cnt, fail_cnt);
      if (fail_cnt == 0)
      begin
         $display("Result: PASSED");
      end
      else
      begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

//--- logic/spart_driver.sv
`timescale 1ns/1ps
// top level of the spart board driver, connects to the spart, the memory, the cpu fetch stage
module spart_driver
   import spart_driver_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   // spart side
   input  br_cfg_t br_cfg_i,
   input  logic    rda_i,
   input  logic    tbr_i,
   input  byte_t   rx_data_i,
   output ioaddr_t ioaddr_o,
   output logic    iorw_o,
   output byte_t   tx_data_o,
   // memory side
   input  word_t   mem_rdata_i,
   output logic    mem_en_o,
   output logic    mem_we_o,
   output maddr_t  mem_addr_o,
   output word_t   mem_wdata_o,
   // cpu and memory system
   input  pc_t     cpu_pc_i,
   input  logic    mem_sys_fin_i,
   output pc_t     ext_pc_o,
   output logic    ext_pc_en_o,
   output logic    flush_o
);

   // dump region, held by the command machine
   maddr_t start_addr;
   maddr_t stop_addr;

   frame_if frm ();
   dump_if  dmp ();

   frame_decode frame_decode0 (
      .clk       (clk),
      .rst_n     (rst_n),
      .rx_data_i (rx_data_i),
      .frm       (frm.decode)
   );

   command_fsm command_fsm0 (
      .clk          (clk),
      .rst_n        (rst_n),
      .br_cfg_i     (br_cfg_i),
      .rda_i        (rda_i),
      .tbr_i        (tbr_i),
      .cpu_pc_i     (cpu_pc_i),
      .frm          (frm.execute),
      .dmp          (dmp.execute),
      .start_addr_o (start_addr),
      .stop_addr_o  (stop_addr),
      .ioaddr_o     (ioaddr_o),
      .iorw_o       (iorw_o),
      .tx_data_o    (tx_data_o),
      .mem_en_o     (mem_en_o),
      .mem_we_o     (mem_we_o),
      .mem_addr_o   (mem_addr_o),
      .mem_wdata_o  (mem_wdata_o),
      .ext_pc_o     (ext_pc_o),
      .ext_pc_en_o  (ext_pc_en_o),
      .flush_o      (flush_o)
   );

   result_dump result_dump0 (
      .clk           (clk),
      .rst_n         (rst_n),
      .tbr_i         (tbr_i),
      .mem_sys_fin_i (mem_sys_fin_i),
      .mem_rdata_i   (mem_rdata_i),
      .start_addr_i  (start_addr),
      .stop_addr_i   (stop_addr),
      .dmp           (dmp.result)
   );

endmodule

//--- logic/result_dump.sv
`timescale 1ns/1ps
// streams a memory region out over the spart after a program run, started by the command machine
module result_dump
   import spart_driver_pkg::*;
(
   input  logic   clk,
   input  logic   rst_n,
   input  logic   tbr_i,
   input  logic   mem_sys_fin_i,
   input  word_t  mem_rdata_i,
   input  maddr_t start_addr_i,
   input  maddr_t stop_addr_i,
   dump_if.result dmp
);

   typedef enum logic [1:0] {
      DMP_IDLE,
      DMP_WAIT,
      DMP_LOAD,
      DMP_SEND
   } dmp_state_t;

   dmp_state_t state_q;
   dmp_state_t state_d;
   maddr_t     addr_q;
   // set once no word is left to read
   logic       past_q;
   // memory system has drained its caches
   logic       fin_q;
   word_t      buf_q;
   // byte lane being sent, 7 first
   logic [2:0] byte_cnt;

   //////////////////////////////////////////////////
   // request and send strobes
   //////////////////////////////////////////////////
   assign dmp.rd_en   = (state_q == DMP_WAIT) && fin_q && !past_q && tbr_i;
   assign dmp.rd_addr = addr_q;
   assign dmp.done    = (state_q == DMP_WAIT) && fin_q && past_q;
   assign dmp.send    = (state_q == DMP_SEND) && tbr_i;
   assign dmp.tx_byte = buf_q[{byte_cnt, 3'b000} +: 8];

   always_comb
   begin
      state_d = state_q;
      if (dmp.start)
      begin
         state_d = DMP_WAIT;
      end
      else
      begin
         case (state_q)
            DMP_WAIT:
            begin
               if (dmp.done)
               begin
                  state_d = DMP_IDLE;
               end
               else if (dmp.rd_en)
               begin
                  state_d = DMP_LOAD;
               end
            end
            // read data shows up one cycle after the address
            DMP_LOAD: state_d = DMP_SEND;
            DMP_SEND:
            begin
               if (dmp.send && (byte_cnt == 3'd0))
               begin
                  state_d = DMP_WAIT;
               end
            end
            default: state_d = DMP_IDLE;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // counters and flags
   //////////////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q  <= DMP_IDLE;
         addr_q   <= '0;
         past_q   <= 1'b1;
         fin_q    <= 1'b0;
         byte_cnt <= '0;
      end
      else
      begin
         state_q <= state_d;
         // an inverted range never reads anything
         if (dmp.start)
         begin
            addr_q <= start_addr_i;
            past_q <= (start_addr_i > stop_addr_i);
         end
         else if (dmp.rd_en)
         begin
            addr_q <= addr_q + 14'd1;
            past_q <= (addr_q == stop_addr_i);
         end
         // the flush goes out with start, so the next fin belongs to it
         if (dmp.start)
         begin
            fin_q <= 1'b0;
         end
         else if (mem_sys_fin_i)
         begin
            fin_q <= 1'b1;
         end
         if (state_q == DMP_LOAD)
         begin
            byte_cnt <= 3'd7;
         end
         else if (dmp.send)
         begin
            byte_cnt <= byte_cnt - 3'd1;
         end
      end
   end

   // word buffer, loaded in the cycle after the read
   always_ff @(posedge clk)
   begin
      if (state_q == DMP_LOAD)
      begin
         buf_q <= mem_rdata_i;
      end
   end

   // bytes leave only into a free transmitter, and only after the flush has completed
   a_send_ready: assert property (
      @(posedge clk) disable iff (!rst_n)
      dmp.send |-> (tbr_i && fin_q)
   );

endmodule

//--- logic/command_fsm.sv
`timescale 1ns/1ps
// main control of the spart driver, owns the spart and memory ports and runs the host commands
module command_fsm
   import spart_driver_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  br_cfg_t  br_cfg_i,
   input  logic     rda_i,
   input  logic     tbr_i,
   input  pc_t      cpu_pc_i,
   frame_if.execute frm,
   dump_if.execute  dmp,
   output maddr_t   start_addr_o,
   output maddr_t   stop_addr_o,
   output ioaddr_t  ioaddr_o,
   output logic     iorw_o,
   output byte_t    tx_data_o,
   output logic     mem_en_o,
   output logic     mem_we_o,
   output maddr_t   mem_addr_o,
   output word_t    mem_wdata_o,
   output pc_t      ext_pc_o,
   output logic     ext_pc_en_o,
   output logic     flush_o
);

   drv_state_t state_q;
   drv_state_t state_d;
   // baud setting last written to the spart
   br_cfg_t    br_cfg_q;
   maddr_t     start_addr_q;
   maddr_t     stop_addr_q;
   logic       start_ld;
   logic       stop_ld;
   divisor_t   divisor;

   assign divisor      = BAUD_DIVISOR[br_cfg_i];
   assign start_addr_o = start_addr_q;
   assign stop_addr_o  = stop_addr_q;

   //////////////////////////////////////////////////
   // state and configuration registers
   //////////////////////////////////////////////////

   // divisor goes out first after reset
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q  <= BAUD_LOW;
         br_cfg_q <= '0;
      end
      else
      begin
         state_q <= state_d;
         if (state_q == BAUD_HIGH)
         begin
            br_cfg_q <= br_cfg_i;
         end
      end
   end

   // region bounds come from the low bits of the frame word
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         start_addr_q <= '0;
         stop_addr_q  <= '0;
      end
      else
      begin
         if (start_ld)
         begin
            start_addr_q <= frm.word[$bits(maddr_t)-1:0];
         end
         if (stop_ld)
         begin
            stop_addr_q <= frm.word[$bits(maddr_t)-1:0];
         end
      end
   end

   //////////////////////////////////////////////////
   // next state and port multiplexers
   //////////////////////////////////////////////////
   always_comb
   begin
      // idle bus polls the status register
      state_d     = state_q;
      ioaddr_o    = IOADDR_STATUS;
      iorw_o      = 1'b1;
      tx_data_o   = '0;
      mem_en_o    = 1'b0;
      mem_we_o    = 1'b0;
      mem_addr_o  = LAST_SLOT_ADDR;
      mem_wdata_o = frm.word;
      ext_pc_o    = '0;
      ext_pc_en_o = 1'b0;
      flush_o     = 1'b0;
      frm.take    = 1'b0;
      frm.cmd_clr = 1'b0;
      dmp.start   = 1'b0;
      start_ld    = 1'b0;
      stop_ld     = 1'b0;
      case (state_q)
         IDLE:
         begin
            // baud change beats rx, rx beats a pending command
            if (br_cfg_i != br_cfg_q)
            begin
               state_d = BAUD_LOW;
            end
            else if (rda_i)
            begin
               ioaddr_o = IOADDR_DATA;
               frm.take = 1'b1;
               state_d  = ECHO;
            end
            else if (frm.cmd == CMD_SEND)
            begin
               // mailbox write and cpu jump in the same cycle
               mem_en_o    = 1'b1;
               mem_we_o    = 1'b1;
               ext_pc_o    = frm.word[15:0];
               ext_pc_en_o = 1'b1;
               frm.cmd_clr = 1'b1;
               state_d     = CLR_MEM;
            end
            else if (frm.cmd == CMD_START)
            begin
               start_ld    = 1'b1;
               frm.cmd_clr = 1'b1;
            end
            else if (frm.cmd == CMD_STOP)
            begin
               stop_ld     = 1'b1;
               frm.cmd_clr = 1'b1;
            end
            else if (frm.cmd != '0)
            begin
               // unknown command characters are dropped
               frm.cmd_clr = 1'b1;
            end
         end
         ECHO:
         begin
            if (tbr_i)
            begin
               ioaddr_o  = IOADDR_DATA;
               iorw_o    = 1'b0;
               tx_data_o = frm.echo_byte;
               state_d   = IDLE;
            end
         end
         BAUD_LOW:
         begin
            ioaddr_o  = IOADDR_DIV_LOW;
            tx_data_o = divisor[7:0];
            state_d   = BAUD_HIGH;
         end
         BAUD_HIGH:
         begin
            ioaddr_o  = IOADDR_DIV_HIGH;
            tx_data_o = divisor[15:8];
            state_d   = IDLE;
         end
         CLR_MEM:
         begin
            // once the cpu has left the loader loop, wipe the mailbox so it runs once
            if (cpu_pc_i > LOOP_PC_MAX)
            begin
               mem_en_o    = 1'b1;
               mem_we_o    = 1'b1;
               mem_wdata_o = '0;
               state_d     = PRG_EXE;
            end
         end
         PRG_EXE:
         begin
            // back in the loop means the program has finished
            if (cpu_pc_i <= LOOP_PC_MAX)
            begin
               flush_o   = 1'b1;
               dmp.start = 1'b1;
               state_d   = DUMP;
            end
         end
         DUMP:
         begin
            mem_en_o   = dmp.rd_en;
            mem_addr_o = dmp.rd_addr;
            if (dmp.send)
            begin
               ioaddr_o  = IOADDR_DATA;
               iorw_o    = 1'b0;
               tx_data_o = dmp.tx_byte;
            end
            if (dmp.done)
            begin
               state_d = IDLE;
            end
         end
         default:
         begin
            state_d = IDLE;
         end
      endcase
   end

   // mailbox writes and dump reads share the memory port
   a_no_wr_in_dump: assert property (
      @(posedge clk) disable iff (!rst_n)
      !(mem_we_o && dmp.rd_en)
   );

   // one flush request per program run
   a_flush_pulse: assert property (
      @(posedge clk) disable iff (!rst_n)
      flush_o |=> !flush_o
   );

endmodule

//--- logic/frame_decode.sv
`timescale 1ns/1ps
// frame assembly for the spart driver, fed by the command machine through frame_if
module frame_decode
   import spart_driver_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  byte_t   rx_data_i,
   frame_if.decode frm
);

   // position inside the frame, 0..7 digits, 8 command
   logic [3:0] dig_cnt;
   logic [3:0] echo_idx;
   byte_t      digit_q [FRAME_DIGITS];
   byte_t      cmd_q;
   byte_t      echo;
   word_t      word_w;
   logic       take_cmd;

   assign take_cmd = frm.take && (dig_cnt == 4'(FRAME_DIGITS));

   // counter wraps after the command character
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         dig_cnt <= '0;
      end
      else if (take_cmd)
      begin
         dig_cnt <= '0;
      end
      else if (frm.take)
      begin
         dig_cnt <= dig_cnt + 4'd1;
      end
   end

   // digits kept as values, slot 0 holds the earliest one
   always_ff @(posedge clk)
   begin
      if (frm.take && !take_cmd)
      begin
         digit_q[dig_cnt[2:0]] <= rx_data_i - ASCII_ZERO;
      end
   end

   // command held until the machine has acted on it
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         cmd_q <= '0;
      end
      else if (frm.cmd_clr)
      begin
         cmd_q <= '0;
      end
      else if (take_cmd)
      begin
         cmd_q <= rx_data_i;
      end
   end

   // earliest digit lands in the top byte
   always_comb
   begin
      for (int i = 0; i < FRAME_DIGITS; i++)
      begin
         word_w[63 - 8*i -: 8] = digit_q[i];
      end
   end

   // counter already points past the byte being echoed
   assign echo_idx = dig_cnt - 4'd1;

   always_comb
   begin
      if (dig_cnt == '0)
      begin
         echo = cmd_q;
      end
      else
      begin
         echo = digit_q[echo_idx[2:0]] + ASCII_ZERO;
      end
   end

   assign frm.word      = word_w;
   assign frm.cmd       = cmd_q;
   assign frm.echo_byte = echo;

   // frame position stays inside eight digits plus one command
   a_dig_cnt_range: assert property (
      @(posedge clk) disable iff (!rst_n)
      dig_cnt <= 4'(FRAME_DIGITS)
   );

endmodule

//--- logic/dump_if.sv
`timescale 1ns/1ps
// link between the command machine and the memory dump, instantiated once in the driver top level
interface dump_if
   import spart_driver_pkg::*;
();

   // one-cycle kick from the command machine
   logic   start;
   // read request toward memory
   logic   rd_en;
   maddr_t rd_addr;
   // byte strobe toward the spart
   logic   send;
   byte_t  tx_byte;
   // one-cycle end of dump
   logic   done;

   modport execute (
      output start,
      input  rd_en,
      input  rd_addr,
      input  send,
      input  tx_byte,
      input  done
   );

   modport result (
      input  start,
      output rd_en,
      output rd_addr,
      output send,
      output tx_byte,
      output done
   );

endinterface

//--- logic/frame_if.sv
`timescale 1ns/1ps
// link between frame assembly and the command machine, instantiated once in the driver top level
interface frame_if
   import spart_driver_pkg::*;
();

   // strobes from the command machine
   logic  take;
   logic  cmd_clr;
   // assembled frame contents
   word_t word;
   byte_t cmd;
   // byte to send back to the host
   byte_t echo_byte;

   modport decode (
      input  take,
      input  cmd_clr,
      output word,
      output cmd,
      output echo_byte
   );

   modport execute (
      output take,
      output cmd_clr,
      input  word,
      input  cmd,
      input  echo_byte
   );

endinterface

//--- logic/spart_driver_pkg.sv
// shared widths, state encoding and constants of the spart driver, imported by every design file
package spart_driver_pkg;

   //////////////////////////////////////////////////
   // data widths
   //////////////////////////////////////////////////

   // one character moved over the spart data register
   typedef logic [7:0]  byte_t;
   // one memory word, also the assembled frame value
   typedef logic [63:0] word_t;
   // word address into the 16k-word memory
   typedef logic [13:0] maddr_t;
   // cpu program counter, as seen at fetch
   typedef logic [15:0] pc_t;
   // baud divisor, split into two register writes
   typedef logic [15:0] divisor_t;
   // board switches that pick the baud rate
   typedef logic [1:0]  br_cfg_t;
   // spart register select
   typedef logic [1:0]  ioaddr_t;

   // main driver state machine
   typedef enum logic [2:0] {
      IDLE,
      ECHO,
      BAUD_LOW,
      BAUD_HIGH,
      CLR_MEM,
      PRG_EXE,
      DUMP
   } drv_state_t;

   //////////////////////////////////////////////////
   // spart register map
   //////////////////////////////////////////////////
   localparam ioaddr_t IOADDR_DATA     = 2'd0;
   localparam ioaddr_t IOADDR_STATUS   = 2'd1;
   localparam ioaddr_t IOADDR_DIV_LOW  = 2'd2;
   localparam ioaddr_t IOADDR_DIV_HIGH = 2'd3;

   // command characters closing a frame ('s', 'a', 'e')
   localparam byte_t CMD_SEND  = 8'h73;
   localparam byte_t CMD_START = 8'h61;
   localparam byte_t CMD_STOP  = 8'h65;

   // digits arrive as ascii and are kept as values
   localparam byte_t       ASCII_ZERO   = 8'h30;
   localparam int unsigned FRAME_DIGITS = 8;

   // loader mailbox slot and the pc range of the loader loop
   localparam maddr_t LAST_SLOT_ADDR = 14'h3fff;
   localparam pc_t    LOOP_PC_MAX    = 16'h0003;

   // divisor per br_cfg setting, slowest rate at index 1
   localparam divisor_t BAUD_DIVISOR [4] = '{16'h0082, 16'h028B, 16'h0146, 16'h00A3};

endpackage
